//--- src/rf_pkg.sv
/*
 * register read subsystem package
 * shared sizes, register and slot types, the collector state encoding,
 * and the mapping from a unit operand to its selector slot
 */

package rf_pkg;

	// ==============================
	// sizes
	// ==============================
	localparam int NUM_UNITS    = 4;
	localparam int OPS_PER_UNIT = 3;
	localparam int NUM_SLOTS    = NUM_UNITS * OPS_PER_UNIT;
	localparam int NUM_RD_PORTS = 8;
	// one fixed port per unit, always carrying that unit's operand 0
	localparam int FIXED_PORTS  = NUM_UNITS;
	localparam int DYN_SLOTS    = NUM_SLOTS - FIXED_PORTS;
	localparam int NUM_REGS     = 32;

	// ==============================
	// types
	// ==============================
	// register zero doubles as "no operand"
	typedef logic [4:0]  aregno_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [3:0]  slot_idx_t;

	typedef enum logic [2:0] {
		COLL_IDLE,
		COLL_REQ,
		COLL_ACK,
		COLL_DRAIN,
		COLL_DONE
	} coll_state_t;

	// operand 0 sits in the fixed slots, the rest follow two per unit
	function automatic int slot_of(input int unit, input int op);
		return (op == 0) ? unit : FIXED_PORTS + unit * 2 + (op - 1);
	endfunction

endpackage

//--- src/rf_rotate_counter.sv
/*
 * rotate counter
 * gives the read-port selector a new starting slot every cycle so
 * that each dynamic slot gets first pick once every DYN_SLOTS cycles
 */

`timescale 1ns/1ps

module rf_rotate_counter (
	input  logic              clk,
	input  logic              rst,
	output rf_pkg::slot_idx_t rot_ptr_o
);
	import rf_pkg::*;

	// the pointer wraps back to zero after the last dynamic slot
	always_ff @(posedge clk) begin
		if (rst) begin
			rot_ptr_o <= '0;
		end else if (rot_ptr_o == slot_idx_t'(DYN_SLOTS - 1)) begin
			rot_ptr_o <= '0;
		end else begin
			rot_ptr_o <= rot_ptr_o + slot_idx_t'(1);
		end
	end

	// the selector indexes dynamic slots with this value, so it must stay in range
	a_ptr_range: assert property (@(posedge clk) disable iff (rst)
		rot_ptr_o < slot_idx_t'(DYN_SLOTS));

endmodule

//--- src/rf_read_select.sv
/*
 * read-port selector
 * maps the twelve operand request slots onto the eight register file
 * read ports: fixed slots own ports 0 to 3, dynamic slots share the rest
 * in a rotating scan, and all outputs are registered
 */

`timescale 1ns/1ps

module rf_read_select (
	input  logic                                        clk,
	input  logic                                        rst,
	input  rf_pkg::aregno_t   [rf_pkg::NUM_SLOTS-1:0]    slot_reg_i,
	input  rf_pkg::slot_idx_t                           rot_ptr_i,
	output logic              [rf_pkg::NUM_SLOTS-1:0]    slot_ack_o,
	output rf_pkg::aregno_t   [rf_pkg::NUM_RD_PORTS-1:0] port_reg_o,
	output rf_pkg::slot_idx_t [rf_pkg::NUM_RD_PORTS-1:0] port_slot_o,
	output logic              [rf_pkg::NUM_RD_PORTS-1:0] port_used_o
);
	import rf_pkg::*;

	logic      [NUM_SLOTS-1:0]    ack_n;
	aregno_t   [NUM_RD_PORTS-1:0] reg_n;
	slot_idx_t [NUM_RD_PORTS-1:0] pslot_n;
	logic      [NUM_RD_PORTS-1:0] used_n;

	// ==============================
	// port assignment
	// ==============================
	always_comb begin
		int fill;
		int scan;
		ack_n   = '0;
		reg_n   = '0;
		pslot_n = '0;
		used_n  = '0;
		// fixed slots need no arbitration, slot u always lands on port u
		for (int u = 0; u < FIXED_PORTS; u++) begin
			reg_n[u]   = slot_reg_i[u];
			pslot_n[u] = slot_idx_t'(u);
			used_n[u]  = (slot_reg_i[u] != '0);
			ack_n[u]   = (slot_reg_i[u] != '0);
		end
		// scan the dynamic slots starting at the rotation point, wrapping
		// around, and pack nonzero requests onto the next free port
		fill = FIXED_PORTS;
		for (int j = 0; j < DYN_SLOTS; j++) begin
			scan = FIXED_PORTS + ((j + int'(rot_ptr_i)) % DYN_SLOTS);
			if (slot_reg_i[scan] != '0 && fill < NUM_RD_PORTS) begin
				ack_n[scan]   = 1'b1;
				reg_n[fill]   = slot_reg_i[scan];
				pslot_n[fill] = slot_idx_t'(scan);
				used_n[fill]  = 1'b1;
				fill = fill + 1;
			end
			// once the ports are full the leftover requests simply get no ack
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_ack_o  <= '0;
			port_used_o <= '0;
		end else begin
			slot_ack_o  <= ack_n;
			port_used_o <= used_n;
		end
	end

	// register number and slot tag follow the valid bits
	always_ff @(posedge clk) begin
		port_reg_o  <= reg_n;
		port_slot_o <= pslot_n;
	end

	// ==============================
	// checks
	// ==============================
	a_dyn_limit: assert property (@(posedge clk) disable iff (rst)
		$countones(slot_ack_o[NUM_SLOTS-1:FIXED_PORTS]) <= NUM_RD_PORTS - FIXED_PORTS);

	for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_chk
		// an ack always answers a real request from the previous cycle
		a_no_zero_ack: assert property (@(posedge clk) disable iff (rst)
			slot_ack_o[s] |-> $past(slot_reg_i[s]) != '0);
	end

endmodule

//--- src/rf_regfile.sv
/*
 * register file
 * 32 by 32-bit registers with eight registered read ports and one write
 * port, register zero always reads as zero
 */

`timescale 1ns/1ps

module rf_regfile (
	input  logic                                        clk,
	input  logic                                        rst,
	input  rf_pkg::aregno_t   [rf_pkg::NUM_RD_PORTS-1:0] rd_reg_i,
	output rf_pkg::reg_data_t [rf_pkg::NUM_RD_PORTS-1:0] rd_data_o,
	input  logic                                        wr_en_i,
	input  rf_pkg::aregno_t                             wr_reg_i,
	input  rf_pkg::reg_data_t                           wr_data_i
);
	import rf_pkg::*;

	reg_data_t regs [NUM_REGS];

	// ==============================
	// write port
	// ==============================
	// reset clears the whole array so every register first reads as zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else if (wr_en_i && wr_reg_i != '0) begin
			// writes to register zero fall on the floor
			regs[wr_reg_i] <= wr_data_i;
		end
	end

	// ==============================
	// read ports
	// ==============================
	// reads sample the array before this edge's write lands, so a read
	// and a write to the same register in one cycle return the old value
	always_ff @(posedge clk) begin
		for (int p = 0; p < NUM_RD_PORTS; p++) begin
			if (rd_reg_i[p] == '0) begin
				rd_data_o[p] <= '0;
			end else begin
				rd_data_o[p] <= regs[rd_reg_i[p]];
			end
		end
	end

endmodule

//--- src/rf_data_route.sv
/*
 * read data router
 * delays the port-to-slot mapping by the register file read latency and
 * steers each port's data back to the operand slot that asked for it
 */

`timescale 1ns/1ps

module rf_data_route (
	input  logic                                        clk,
	input  logic                                        rst,
	input  rf_pkg::slot_idx_t [rf_pkg::NUM_RD_PORTS-1:0] port_slot_i,
	input  logic              [rf_pkg::NUM_RD_PORTS-1:0] port_used_i,
	input  rf_pkg::reg_data_t [rf_pkg::NUM_RD_PORTS-1:0] rd_data_i,
	output logic              [rf_pkg::NUM_SLOTS-1:0]    slot_valid_o,
	output rf_pkg::reg_data_t [rf_pkg::NUM_SLOTS-1:0]    slot_data_o
);
	import rf_pkg::*;

	slot_idx_t [NUM_RD_PORTS-1:0] port_slot_q;
	logic      [NUM_RD_PORTS-1:0] port_used_q;

	// the regfile answers one cycle after it sees the port numbers, so the
	// mapping is held for exactly that long
	always_ff @(posedge clk) begin
		if (rst) begin
			port_used_q <= '0;
		end else begin
			port_used_q <= port_used_i;
		end
	end

	always_ff @(posedge clk) begin
		port_slot_q <= port_slot_i;
	end

	// each used port drives the slot it was granted to
	always_comb begin
		slot_valid_o = '0;
		slot_data_o  = '0;
		for (int p = 0; p < NUM_RD_PORTS; p++) begin
			if (port_used_q[p]) begin
				slot_valid_o[port_slot_q[p]] = 1'b1;
				slot_data_o[port_slot_q[p]]  = rd_data_i[p];
			end
		end
	end

	// the selector must never grant one slot twice in a cycle
	for (genvar a = 0; a < NUM_RD_PORTS; a++) begin : g_chk_a
		for (genvar b = a + 1; b < NUM_RD_PORTS; b++) begin : g_chk_b
			a_unique_slot: assert property (@(posedge clk) disable iff (rst)
				!(port_used_q[a] && port_used_q[b] && port_slot_q[a] == port_slot_q[b]));
		end
	end

endmodule

//--- src/rf_operand_collector.sv
/*
 * operand collector
 * one per functional unit: latches up to three source registers on
 * issue, requests them in one-cycle windows, retries the ones that
 * were not granted, gathers the read data and pulses ready
 */

`timescale 1ns/1ps

module rf_operand_collector (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        issue_i,
	input  rf_pkg::aregno_t   [rf_pkg::OPS_PER_UNIT-1:0] issue_reg_i,
	output logic                                        busy_o,
	output rf_pkg::aregno_t   [rf_pkg::OPS_PER_UNIT-1:0] req_reg_o,
	input  logic              [rf_pkg::OPS_PER_UNIT-1:0] ack_i,
	input  logic              [rf_pkg::OPS_PER_UNIT-1:0] data_valid_i,
	input  rf_pkg::reg_data_t [rf_pkg::OPS_PER_UNIT-1:0] data_i,
	output logic                                        ready_o,
	output rf_pkg::reg_data_t [rf_pkg::OPS_PER_UNIT-1:0] op_data_o
);
	import rf_pkg::*;

	coll_state_t                 state_q;
	aregno_t [OPS_PER_UNIT-1:0]  regs_q;
	// pend_q marks operands still waiting for a grant and coll_q those already in hand
	logic    [OPS_PER_UNIT-1:0]  pend_q;
	logic    [OPS_PER_UNIT-1:0]  coll_q;
	logic    [OPS_PER_UNIT-1:0]  nz_mask;
	logic    [OPS_PER_UNIT-1:0]  pend_left;

	always_comb begin
		for (int k = 0; k < OPS_PER_UNIT; k++) begin
			nz_mask[k] = (issue_reg_i[k] != '0);
		end
	end

	assign pend_left = pend_q & ~ack_i;

	// ==============================
	// state machine
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= COLL_IDLE;
			pend_q  <= '0;
			coll_q  <= '0;
		end else begin
			// data can land in any busy state, including a retry round
			if (state_q != COLL_IDLE) begin
				coll_q <= coll_q | data_valid_i;
			end
			case (state_q)
			COLL_IDLE: begin
				if (issue_i) begin
					pend_q  <= nz_mask;
					// zero operands count as collected right away
					coll_q  <= ~nz_mask;
					state_q <= (nz_mask == '0) ? COLL_DONE : COLL_REQ;
				end
			end
			COLL_REQ: state_q <= COLL_ACK;
			COLL_ACK: begin
				pend_q  <= pend_left;
				state_q <= (pend_left != '0) ? COLL_REQ : COLL_DRAIN;
			end
			// waits on the registered mask, so data seen this cycle is counted next
			COLL_DRAIN: if (&coll_q) state_q <= COLL_DONE;
			COLL_DONE: state_q <= COLL_IDLE;
			default: state_q <= COLL_IDLE;
			endcase
		end
	end

	// register numbers latch on issue and operand values as their read data lands
	always_ff @(posedge clk) begin
		if (state_q == COLL_IDLE && issue_i) begin
			regs_q    <= issue_reg_i;
			op_data_o <= '0;
		end else begin
			for (int k = 0; k < OPS_PER_UNIT; k++) begin
				if (data_valid_i[k]) op_data_o[k] <= data_i[k];
			end
		end
	end

	// requests go out only in the one-cycle REQ window, so a grant can
	// never be issued twice for the same outstanding operand
	always_comb begin
		for (int k = 0; k < OPS_PER_UNIT; k++) begin
			req_reg_o[k] = (state_q == COLL_REQ && pend_q[k]) ? regs_q[k] : '0;
		end
	end

	assign busy_o  = (state_q != COLL_IDLE);
	assign ready_o = (state_q == COLL_DONE);

	// the selector's registered ack lines up with the ACK state only
	a_ack_window: assert property (@(posedge clk) disable iff (rst)
		(|ack_i) |-> state_q == COLL_ACK);

endmodule

//--- src/rf_read_subsystem.sv
/*
 * register read subsystem
 * four operand collectors share eight register file read ports through
 * the rotating selector, the router returns the data to each collector
 */

`timescale 1ns/1ps

module rf_read_subsystem (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic              [rf_pkg::NUM_UNITS-1:0]    issue_i,
	input  rf_pkg::aregno_t   [rf_pkg::NUM_SLOTS-1:0]    issue_reg_i,
	output logic              [rf_pkg::NUM_UNITS-1:0]    busy_o,
	output logic              [rf_pkg::NUM_UNITS-1:0]    ready_o,
	output rf_pkg::reg_data_t [rf_pkg::NUM_SLOTS-1:0]    op_data_o,
	input  logic                                        wr_en_i,
	input  rf_pkg::aregno_t                             wr_reg_i,
	input  rf_pkg::reg_data_t                           wr_data_i
);
	import rf_pkg::*;

	// slot-ordered buses between collectors, selector and router
	aregno_t   [NUM_SLOTS-1:0]    slot_reg;
	logic      [NUM_SLOTS-1:0]    slot_ack;
	logic      [NUM_SLOTS-1:0]    slot_valid;
	reg_data_t [NUM_SLOTS-1:0]    slot_data;
	slot_idx_t                    rot_ptr;
	aregno_t   [NUM_RD_PORTS-1:0] port_reg;
	slot_idx_t [NUM_RD_PORTS-1:0] port_slot;
	logic      [NUM_RD_PORTS-1:0] port_used;
	reg_data_t [NUM_RD_PORTS-1:0] rd_data;

	rf_rotate_counter rf_rotate_counter_inst (
		.clk(clk), .rst(rst), .rot_ptr_o(rot_ptr)
	);

	rf_read_select rf_read_select_inst (
		.clk(clk), .rst(rst), .slot_reg_i(slot_reg), .rot_ptr_i(rot_ptr),
		.slot_ack_o(slot_ack), .port_reg_o(port_reg), .port_slot_o(port_slot),
		.port_used_o(port_used)
	);

	rf_regfile rf_regfile_inst (
		.clk(clk), .rst(rst), .rd_reg_i(port_reg), .rd_data_o(rd_data),
		.wr_en_i(wr_en_i), .wr_reg_i(wr_reg_i), .wr_data_i(wr_data_i)
	);

	rf_data_route rf_data_route_inst (
		.clk(clk), .rst(rst), .port_slot_i(port_slot), .port_used_i(port_used),
		.rd_data_i(rd_data), .slot_valid_o(slot_valid), .slot_data_o(slot_data)
	);

	// ==============================
	// collectors
	// ==============================
	for (genvar u = 0; u < NUM_UNITS; u++) begin : g_unit
		aregno_t   [OPS_PER_UNIT-1:0] unit_req;
		logic      [OPS_PER_UNIT-1:0] unit_ack;
		logic      [OPS_PER_UNIT-1:0] unit_valid;
		reg_data_t [OPS_PER_UNIT-1:0] unit_data;

		// unit-major operand k of unit u travels on slot slot_of(u, k)
		for (genvar k = 0; k < OPS_PER_UNIT; k++) begin : g_op
			localparam int SLOT = slot_of(u, k);
			assign slot_reg[SLOT] = unit_req[k];
			assign unit_ack[k]    = slot_ack[SLOT];
			assign unit_valid[k]  = slot_valid[SLOT];
			assign unit_data[k]   = slot_data[SLOT];
		end

		rf_operand_collector rf_operand_collector_inst (
			.clk(clk), .rst(rst), .issue_i(issue_i[u]),
			.issue_reg_i(issue_reg_i[u*OPS_PER_UNIT +: OPS_PER_UNIT]),
			.busy_o(busy_o[u]), .req_reg_o(unit_req), .ack_i(unit_ack),
			.data_valid_i(unit_valid), .data_i(unit_data), .ready_o(ready_o[u]),
			.op_data_o(op_data_o[u*OPS_PER_UNIT +: OPS_PER_UNIT])
		);
	end

endmodule

//--- tests/tb_rf_model.svh
/*
 * reference model for the register read testbench
 * keeps a shadow of the architectural registers and predicts the
 * value that each operand slot should deliver
 */

`ifndef TB_RF_MODEL_SVH
`define TB_RF_MODEL_SVH

// shadow of the register array, cleared like the DUT at reset
reg_data_t shadow_regs [NUM_REGS];

task automatic shadow_clear();
	for (int r = 0; r < NUM_REGS; r++) begin
		shadow_regs[r] = '0;
	end
endtask

// mirrors every write that the testbench drives
task automatic shadow_write(input aregno_t r, input reg_data_t d);
	shadow_regs[r] = d;
endtask

// register zero means no operand and always delivers zero
function automatic reg_data_t expected_operand(input aregno_t r);
	if (r == '0) begin
		return '0;
	end
	return shadow_regs[r];
endfunction

`endif

//--- tests/tb_rf_read.sv
/*
 * testbench for the register read subsystem
 * drives writes and issues into four operand collectors, predicts each
 * unit's operands from a shadow register file at issue time and checks
 * busy every cycle and every ready pulse, its latency where it is fixed,
 * and its data
 */

`timescale 1ns/1ps

module tb_rf_read;
	import rf_pkg::*;

	`include "tb_rf_model.svh"

	localparam int CLK_PERIOD       = 10;
	localparam int RESET_CYCLES     = 8;
	localparam int DIRECTED_ISSUES  = 8;
	localparam int RAND_ISSUES      = 64;
	localparam int TOTAL_ISSUES     = DIRECTED_ISSUES + RAND_ISSUES;
	localparam int CYCLES_PER_ISSUE = 40;

	logic                               clk = 1'b0;
	logic                               rst;
	logic      [NUM_UNITS-1:0]          issue_i;
	aregno_t   [NUM_SLOTS-1:0]          issue_reg_i;
	logic      [NUM_UNITS-1:0]          busy_o;
	logic      [NUM_UNITS-1:0]          ready_o;
	reg_data_t [NUM_SLOTS-1:0]          op_data_o;
	logic                               wr_en_i;
	aregno_t                            wr_reg_i;
	reg_data_t                          wr_data_i;

	// per-unit record of the operation in flight, unit-major operands
	aregno_t   in_reg [NUM_UNITS][OPS_PER_UNIT];
	reg_data_t exp_op [NUM_UNITS][OPS_PER_UNIT];
	bit        inflight [NUM_UNITS];
	int        issue_cyc [NUM_UNITS];
	int        want_lat [NUM_UNITS];
	int        cyc = 0;
	int        issues = 0;
	int        completions = 0;

	rf_read_subsystem rf_read_subsystem_inst (
		.clk(clk), .rst(rst), .issue_i(issue_i), .issue_reg_i(issue_reg_i),
		.busy_o(busy_o), .ready_o(ready_o), .op_data_o(op_data_o),
		.wr_en_i(wr_en_i), .wr_reg_i(wr_reg_i), .wr_data_i(wr_data_i)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ==============================
	// helpers
	// ==============================
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_ready(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
		end
	endtask

	// inputs change one time unit after the edge, strobes last one cycle
	task automatic next_cycle();
		@(posedge clk);
		#1;
		issue_i = '0;
		wr_en_i = 1'b0;
	endtask

	task automatic write_reg(input aregno_t r, input reg_data_t d);
		wr_en_i   = 1'b1;
		wr_reg_i  = r;
		wr_data_i = d;
		shadow_write(r, d);
	endtask

	// lat of zero means the latency depends on contention and is not checked
	task automatic issue_unit(input int u, input aregno_t r0, r1, r2, input int lat);
		aregno_t regs [OPS_PER_UNIT];
		regs[0] = r0;
		regs[1] = r1;
		regs[2] = r2;
		issue_i[u] = 1'b1;
		for (int k = 0; k < OPS_PER_UNIT; k++) begin
			issue_reg_i[u*OPS_PER_UNIT + k] = regs[k];
			in_reg[u][k] = regs[k];
			exp_op[u][k] = expected_operand(regs[k]);
		end
		issue_cyc[u] = cyc;
		want_lat[u]  = lat;
		inflight[u]  = 1'b1;
		issues++;
	endtask

	// a register that an unfinished operation still has to read
	function automatic bit reg_in_use(input aregno_t r);
		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int k = 0; k < OPS_PER_UNIT; k++) begin
				if (inflight[u] && in_reg[u][k] == r) return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic wait_all_done();
		while (completions != issues) begin
			next_cycle();
		end
	endtask

	// ==============================
	// scoreboard
	// ==============================
	// outputs are sampled at the edge, before the DUT's updates for that edge land
	always @(posedge clk) begin
		int lat;
		if (!rst) begin
			for (int u = 0; u < NUM_UNITS; u++) begin
				// busy from the cycle after the issue up to and including the ready pulse
				check_ready($sformatf("busy_o[%0d]", u), busy_o[u],
					inflight[u] && cyc > issue_cyc[u]);
				if (ready_o[u]) begin
					check_ready($sformatf("ready_o[%0d]", u), ready_o[u], inflight[u]);
					lat = cyc - issue_cyc[u];
					if (want_lat[u] != 0 && lat != want_lat[u]) begin
						abort_run($sformatf("unit %0d became ready %0d cycles after issue, not %0d",
							u, lat, want_lat[u]));
					end
					for (int k = 0; k < OPS_PER_UNIT; k++) begin
						check_data($sformatf("op_data_o[%0d]", u*OPS_PER_UNIT + k),
							op_data_o[u*OPS_PER_UNIT + k], exp_op[u][k]);
					end
					inflight[u] = 1'b0;
					completions++;
				end
			end
		end
		cyc++;
	end

	initial begin
		#((TOTAL_ISSUES * CYCLES_PER_ISSUE + RESET_CYCLES) * CLK_PERIOD);
		abort_run("watchdog expired before every issued operation completed");
	end

	// ==============================
	// stimulus
	// ==============================
	initial begin
		int rand_done;
		aregno_t wr;
		void'($urandom(32'h17ddca55));
		rst         = 1'b1;
		issue_i     = '0;
		issue_reg_i = '0;
		wr_en_i     = 1'b0;
		wr_reg_i    = '0;
		wr_data_i   = '0;
		shadow_clear();
		for (int u = 0; u < NUM_UNITS; u++) begin
			inflight[u] = 1'b0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// quiet outputs after reset, then a read of untouched registers
		for (int u = 0; u < NUM_UNITS; u++) begin
			check_ready($sformatf("busy_o[%0d]", u), busy_o[u], 1'b0);
			check_ready($sformatf("ready_o[%0d]", u), ready_o[u], 1'b0);
		end
		next_cycle();
		issue_unit(0, 5'd1, 5'd2, 5'd3, 5);
		wait_all_done();

		// fill every register with a pattern built from its number
		for (int r = 1; r < NUM_REGS; r++) begin
			next_cycle();
			write_reg(aregno_t'(r), reg_data_t'(r) * 32'h9e3779b1 ^ 32'h5a5a0000);
		end
		next_cycle();
		issue_unit(2, 5'd5, 5'd17, 5'd31, 5);
		wait_all_done();

		// register zero ignores writes and reads as zero
		next_cycle();
		write_reg(5'd0, 32'hdeadbeef);
		next_cycle();
		issue_unit(1, 5'd0, 5'd9, 5'd0, 5);
		wait_all_done();
		next_cycle();
		issue_unit(3, 5'd0, 5'd0, 5'd0, 1);
		wait_all_done();

		// twelve requests against eight ports in one cycle
		next_cycle();
		issue_unit(0, 5'd4, 5'd8, 5'd12, 0);
		issue_unit(1, 5'd16, 5'd20, 5'd24, 0);
		issue_unit(2, 5'd28, 5'd30, 5'd6, 0);
		issue_unit(3, 5'd10, 5'd14, 5'd18, 0);
		wait_all_done();

		// random writes to free registers, random issues on idle units
		rand_done = 0;
		while (rand_done < RAND_ISSUES) begin
			next_cycle();
			wr = aregno_t'($urandom % NUM_REGS);
			if ($urandom % 3 == 0 && !reg_in_use(wr)) begin
				write_reg(wr, reg_data_t'($urandom));
			end
			for (int u = 0; u < NUM_UNITS; u++) begin
				if (rand_done < RAND_ISSUES && !inflight[u] && !busy_o[u] && $urandom % 2 == 0) begin
					issue_unit(u, aregno_t'($urandom % NUM_REGS), aregno_t'($urandom % NUM_REGS),
						aregno_t'($urandom % NUM_REGS), 0);
					rand_done++;
				end
			end
		end
		wait_all_done();
		repeat (4) next_cycle();

		if (completions == issues && issues == TOTAL_ISSUES) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run($sformatf("%0d issues but %0d completions", issues, completions));
		end
	end

endmodule

//--- sim.f
+incdir+tests
src/rf_pkg.sv
src/rf_rotate_counter.sv
src/rf_read_select.sv
src/rf_regfile.sv
src/rf_data_route.sv
src/rf_operand_collector.sv
src/rf_read_subsystem.sv
tests/tb_rf_read.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert -Wno-fatal -j 0 --top-module tb_rf_read -f sim.f
	-./obj_dir/Vtb_rf_read > sim.log 2>&1
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "test failed"; exit 1; fi
	@if ! grep -q "=== PASS ===" sim.log; then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf obj_dir sim.log
